// File: logic/beat_fifo.sv
`timescale 1ns/100ps

module beat_fifo
    import vdma_pkg::*;
#(
    parameter int FIFO_DEPTH = 16
) (
    input  logic              ui_clk,
    input  logic              ui_rstn,
    input  logic              flush_i,
    input  logic              push_i,
    input  beat_t             push_data_i,
    input  logic              pop_i,
    output beat_t             head_o,
    output logic [SIZE_W-1:0] level_o,
    output logic              full_o
);

    localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
    localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

    beat_t             mem [FIFO_DEPTH];
    logic [PTR_W-1:0]  wr_ptr;
    logic [PTR_W-1:0]  rd_ptr;
    logic [CNT_W-1:0]  count;
    logic              do_push;
    logic              do_pop;

    assign full_o  = (count == CNT_W'(FIFO_DEPTH));
    assign level_o = SIZE_W'(count);
    assign do_push = push_i && !full_o;
    assign do_pop  = pop_i && (count != '0);
    assign head_o  = mem[rd_ptr];   // fwft

    always_ff @(posedge ui_clk) begin
        if (!ui_rstn || flush_i) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push)
                wr_ptr <= (wr_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            if (do_pop)
                rd_ptr <= (rd_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            if (do_push && !do_pop)
                count <= count + 1'b1;
            else if (do_pop && !do_push)
                count <= count - 1'b1;
        end
    end

    always_ff @(posedge ui_clk) begin
        if (do_push)
            mem[wr_ptr] <= push_data_i;
    end

    a_no_underflow: assert property (@(posedge ui_clk) disable iff (!ui_rstn)
        pop_i |-> count != '0);

    a_no_overflow: assert property (@(posedge ui_clk) disable iff (!ui_rstn)
        push_i |-> !full_o);

endmodule

// File: logic/burst_addr_gen.sv
`timescale 1ns/100ps

module burst_addr_gen
    import vdma_pkg::*;
#(
    parameter int X_SIZE   = 16,
    parameter int Y_SIZE   = 4,
    parameter int X_STRIDE = 24,
    parameter int X_DIV    = 2
) (
    input  logic      ui_clk,
    input  logic      ui_rstn,
    burst_step_if.gen step
);

    localparam int BURSTS   = Y_SIZE * X_DIV;
    localparam int BCNT_W   = (BURSTS > 1) ? $clog2(BURSTS) : 1;
    localparam int SCNT_W   = (X_DIV > 1) ? $clog2(X_DIV) : 1;
    localparam int STEP_INC = X_SIZE / X_DIV;
    localparam int LINE_INC = STEP_INC + X_STRIDE - X_SIZE;   // jump to next line start

    logic [BCNT_W-1:0] burst_cnt;
    logic [SCNT_W-1:0] sect_cnt;
    logic              frame_done;

    assign step.last_burst = (burst_cnt == BCNT_W'(BURSTS - 1));

    always_ff @(posedge ui_clk) begin
        if (!ui_rstn) begin
            burst_cnt   <= '0;
            sect_cnt    <= '0;
            step.offset <= '0;
            frame_done  <= 1'b0;
        end else if (step.frame_start) begin
            burst_cnt   <= '0;
            sect_cnt    <= '0;
            step.offset <= '0;
            frame_done  <= 1'b0;
        end else if (step.burst_done) begin
            if (step.last_burst) begin
                frame_done <= 1'b1;
            end else begin
                burst_cnt <= burst_cnt + 1'b1;
                if (sect_cnt == SCNT_W'(X_DIV - 1)) begin   // last section of the line
                    sect_cnt    <= '0;
                    step.offset <= step.offset + ofs_t'(LINE_INC);
                end else begin
                    sect_cnt    <= sect_cnt + 1'b1;
                    step.offset <= step.offset + ofs_t'(STEP_INC);
                end
            end
        end
    end

    a_no_extra_burst: assert property (@(posedge ui_clk) disable iff (!ui_rstn)
        step.burst_done |-> !frame_done);

endmodule

// File: logic/burst_step_if.sv
`timescale 1ns/100ps

interface burst_step_if
    import vdma_pkg::*;
    ();

    logic frame_start;  // one cycle, new frame
    logic burst_done;   // one cycle, burst finished
    ofs_t offset;
    logic last_burst;   // current burst closes the frame

    modport fsm (
        output frame_start,
        output burst_done,
        input  offset,
        input  last_burst
    );

    modport gen (
        input  frame_start,
        input  burst_done,
        output offset,
        output last_burst
    );

endinterface

// File: logic/frame_write_fsm.sv
`timescale 1ns/100ps

module frame_write_fsm
    import vdma_pkg::*;
#(
    parameter int BUF_COUNT = 3
) (
    input  logic              ui_clk,
    input  logic              ui_rstn,
    input  logic              fs_i,
    input  bufn_t             buf_sel_i,
    input  logic [SIZE_W-1:0] fifo_level_i,
    input  logic [SIZE_W-1:0] burst_beats_i,
    input  logic              dma_busy_i,
    output logic              wareq_o,
    output logic              flush_o,
    output bufn_t             bufn_o,
    output bufn_t             sync_cnt_o,
    burst_step_if.fsm         step
);

    localparam int FT_W = (FLUSH_CYCLES > 1) ? $clog2(FLUSH_CYCLES) : 1;

    wstate_t         state;
    logic            fs_q;
    logic            fs_qq;
    logic            fs_rise;
    logic [FT_W-1:0] flush_cnt;

    always_ff @(posedge ui_clk) begin
        if (!ui_rstn) begin
            fs_q  <= 1'b0;
            fs_qq <= 1'b0;
        end else begin
            fs_q  <= fs_i;
            fs_qq <= fs_q;
        end
    end

    assign fs_rise = fs_q & ~fs_qq;   // seen one cycle after the edge

    assign step.frame_start = (state == IDLE) && fs_rise;
    assign step.burst_done  = (state == BURST) && !dma_busy_i;

    always_ff @(posedge ui_clk) begin
        if (!ui_rstn) begin
            state      <= IDLE;
            wareq_o    <= 1'b0;
            flush_o    <= 1'b0;
            flush_cnt  <= '0;
            bufn_o     <= '0;
            sync_cnt_o <= '0;
        end else begin
            case (state)
                IDLE: begin
                    if (fs_rise) begin
                        state     <= FLUSH;
                        flush_o   <= 1'b1;
                        flush_cnt <= '0;
                        bufn_o    <= buf_sel_i;
                        if (sync_cnt_o == bufn_t'(BUF_COUNT - 1))
                            sync_cnt_o <= '0;
                        else
                            sync_cnt_o <= sync_cnt_o + 1'b1;
                    end
                end
                FLUSH: begin
                    flush_cnt <= flush_cnt + 1'b1;
                    if (flush_cnt == FT_W'(FLUSH_CYCLES - 1)) begin
                        state   <= REQ;
                        flush_o <= 1'b0;
                    end
                end
                REQ: begin
                    if (wareq_o && dma_busy_i) begin   // engine took the request
                        wareq_o <= 1'b0;
                        state   <= BURST;
                    end else if (!dma_busy_i && fifo_level_i >= burst_beats_i) begin
                        wareq_o <= 1'b1;
                    end
                end
                BURST: begin
                    if (!dma_busy_i)
                        state <= step.last_burst ? IDLE : REQ;
                end
                default: state <= IDLE;
            endcase
        end
    end

    a_req_not_busy: assert property (@(posedge ui_clk) disable iff (!ui_rstn)
        $rose(wareq_o) |-> !$past(dma_busy_i));

    a_flush_in_flush: assert property (@(posedge ui_clk) disable iff (!ui_rstn)
        flush_o |-> state == FLUSH);

endmodule

// File: logic/pixel_packer.sv
`timescale 1ns/100ps

module pixel_packer
    import vdma_pkg::*;
(
    input  logic  ui_clk,
    input  logic  ui_rstn,
    input  logic  flush_i,
    input  logic  pix_valid_i,
    input  pix_t  pix_i,
    output logic  beat_valid_o,
    output beat_t beat_o
);

    localparam int PCNT_W = (PACK_RATIO > 1) ? $clog2(PACK_RATIO) : 1;

    logic [PCNT_W-1:0] pix_cnt;
    beat_t             acc;
    beat_t             acc_next;

    // shift in from the top so the first pixel ends up lowest
    assign acc_next = {pix_i, acc[BEAT_W-1:PIX_W]};

    always_ff @(posedge ui_clk) begin
        if (!ui_rstn || flush_i) begin
            pix_cnt      <= '0;
            beat_valid_o <= 1'b0;
        end else begin
            beat_valid_o <= 1'b0;
            if (pix_valid_i) begin
                if (pix_cnt == PCNT_W'(PACK_RATIO - 1)) begin
                    pix_cnt      <= '0;
                    beat_valid_o <= 1'b1;
                end else begin
                    pix_cnt <= pix_cnt + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge ui_clk) begin
        if (pix_valid_i) begin
            acc    <= acc_next;
            beat_o <= acc_next;   // only sampled with beat_valid_o
        end
    end

endmodule

// File: logic/vdma_pkg.sv
package vdma_pkg;

    localparam int PIX_W        = 32;
    localparam int BEAT_W       = 64;
    localparam int PACK_RATIO   = BEAT_W / PIX_W;   // pixels per beat
    localparam int ADDR_W       = 28;
    localparam int OFS_BITS     = 22;               // buffer index sits above this
    localparam int BUFN_W       = 8;
    localparam int SIZE_W       = 16;               // beat counts, fifo level, burst size
    localparam int FLUSH_CYCLES = 16;

    typedef logic [PIX_W-1:0]    pix_t;
    typedef logic [BEAT_W-1:0]   beat_t;
    typedef logic [ADDR_W-1:0]   addr_t;
    typedef logic [OFS_BITS-1:0] ofs_t;             // in 32-bit words
    typedef logic [BUFN_W-1:0]   bufn_t;

    typedef enum logic [1:0] {
        IDLE  = 2'd0,
        FLUSH = 2'd1,
        REQ   = 2'd2,
        BURST = 2'd3
    } wstate_t;

endpackage

// File: logic/vdma_write_top.sv
`timescale 1ns/100ps

module vdma_write_top
    import vdma_pkg::*;
#(
    parameter int X_SIZE     = 16,
    parameter int Y_SIZE     = 4,
    parameter int X_STRIDE   = 24,
    parameter int X_DIV      = 2,
    parameter int BUF_COUNT  = 3,
    parameter int FIFO_DEPTH = 16
) (
    input  logic              ui_clk,
    input  logic              ui_rstn,
    input  logic              fs_i,
    input  logic              pix_valid_i,
    input  pix_t              pix_i,
    input  bufn_t             buf_sel_i,
    input  addr_t             base_addr_i,
    input  logic              dma_busy_i,
    input  logic              dma_wvalid_i,
    output logic              full_o,
    output bufn_t             sync_cnt_o,
    output addr_t             waddr_o,
    output logic              wareq_o,
    output logic [SIZE_W-1:0] wsize_o,
    output beat_t             wdata_o,
    output logic              wready_o
);

    localparam int BURST_BEATS = X_SIZE / (PACK_RATIO * X_DIV);

    logic              flush;
    logic              pix_take;
    logic              beat_valid;
    beat_t             beat;
    logic [SIZE_W-1:0] fifo_level;
    bufn_t             bufn;
    addr_t             buf_base;

    burst_step_if step ();

    assign wsize_o  = SIZE_W'(BURST_BEATS);
    assign wready_o = 1'b1;
    assign pix_take = pix_valid_i && !full_o;   // pixels dropped while full

    assign buf_base = addr_t'({bufn, {OFS_BITS{1'b0}}});
    assign waddr_o  = base_addr_i + buf_base + addr_t'(step.offset);

    frame_write_fsm #(
        .BUF_COUNT (BUF_COUNT)
    ) frame_write_fsm_i (
        .ui_clk        (ui_clk),
        .ui_rstn       (ui_rstn),
        .fs_i          (fs_i),
        .buf_sel_i     (buf_sel_i),
        .fifo_level_i  (fifo_level),
        .burst_beats_i (wsize_o),
        .dma_busy_i    (dma_busy_i),
        .wareq_o       (wareq_o),
        .flush_o       (flush),
        .bufn_o        (bufn),
        .sync_cnt_o    (sync_cnt_o),
        .step          (step.fsm)
    );

    burst_addr_gen #(
        .X_SIZE   (X_SIZE),
        .Y_SIZE   (Y_SIZE),
        .X_STRIDE (X_STRIDE),
        .X_DIV    (X_DIV)
    ) burst_addr_gen_i (
        .ui_clk  (ui_clk),
        .ui_rstn (ui_rstn),
        .step    (step.gen)
    );

    pixel_packer pixel_packer_i (
        .ui_clk       (ui_clk),
        .ui_rstn      (ui_rstn),
        .flush_i      (flush),
        .pix_valid_i  (pix_take),
        .pix_i        (pix_i),
        .beat_valid_o (beat_valid),
        .beat_o       (beat)
    );

    beat_fifo #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) beat_fifo_i (
        .ui_clk      (ui_clk),
        .ui_rstn     (ui_rstn),
        .flush_i     (flush),
        .push_i      (beat_valid),
        .push_data_i (beat),
        .pop_i       (dma_wvalid_i),
        .head_o      (wdata_o),
        .level_o     (fifo_level),
        .full_o      (full_o)
    );

endmodule

// File: tb.f
logic/vdma_pkg.sv
logic/burst_step_if.sv
logic/frame_write_fsm.sv
logic/burst_addr_gen.sv
logic/pixel_packer.sv
logic/beat_fifo.sv
logic/vdma_write_top.sv
verification/tb_vdma_write.sv

// File: verification/tb_vdma_write.sv
`timescale 1ns/100ps

module tb_vdma_write
    import vdma_pkg::*;
    ();

    localparam int X_SIZE     = 16;
    localparam int Y_SIZE     = 4;
    localparam int X_STRIDE   = 24;
    localparam int X_DIV      = 2;
    localparam int BUF_COUNT  = 3;
    localparam int FIFO_DEPTH = 16;
    localparam int BURSTS     = Y_SIZE * X_DIV;
    localparam int BEATS      = 4;   // 8 pixels per section, 2 per beat
    localparam int FRAMES     = 4;
    localparam int TIMEOUT    = 2000;
    localparam logic [31:0] SEED = 32'h2a460200;
    localparam addr_t BASE = 28'h0040000;
    localparam bufn_t BUF_SEL [FRAMES] = '{8'd3, 8'd1, 8'd6, 8'd2};

    logic ui_clk;
    logic ui_rstn;
    logic fs_i;
    logic pix_valid_i;
    logic dma_busy_i;
    logic dma_wvalid_i;
    pix_t pix_i;
    bufn_t buf_sel_i;
    bufn_t sync_cnt_o;
    addr_t base_addr_i;
    addr_t waddr_o;
    logic full_o;
    logic wareq_o;
    logic wready_o;
    logic [SIZE_W-1:0] wsize_o;
    beat_t wdata_o;

    addr_t exp_addr[$];
    addr_t got_addr[$];
    beat_t exp_beat[$];
    beat_t got_beat[$];
    logic [31:0] pix_st;
    logic [31:0] eng_st;
    int errors = 0;
    int tests = 0;
    int failed = 0;
    int bursts_seen = 0;

    vdma_write_top #(
        .X_SIZE     (X_SIZE),
        .Y_SIZE     (Y_SIZE),
        .X_STRIDE   (X_STRIDE),
        .X_DIV      (X_DIV),
        .BUF_COUNT  (BUF_COUNT),
        .FIFO_DEPTH (FIFO_DEPTH)
    ) vdma_write_top_i (.*);

    initial begin
        ui_clk = 1'b0;
        forever #5 ui_clk = ~ui_clk;
    end

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [31:0] take_bits(inout logic [31:0] st, input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            st = lfsr_next(st);
            r  = {r[30:0], st[31]};
        end
        return r;
    endfunction

    // burst k sits on line k/X_DIV, section k%X_DIV
    function automatic addr_t ref_addr(input addr_t base, input bufn_t bufn, input int k);
        int ofs;
        ofs = (k / X_DIV) * X_STRIDE + (k % X_DIV) * (X_SIZE / X_DIV);
        return base + (addr_t'(bufn) << OFS_BITS) + addr_t'(ofs);
    endfunction

    function automatic beat_t ref_beat(input pix_t first, input pix_t second);
        return {second, first};   // first pixel low
    endfunction

    task automatic abort_run(input string what);
        $display("timeout: %s", what);
        $display("** FAIL **");
        $finish;
    endtask

    task automatic report_test(input string name, input int err_before);
        tests++;
        if (errors == err_before) begin
            $display("test %s: ok", name);
        end else begin
            failed++;
            $display("test %s: %0d errors", name, errors - err_before);
        end
    endtask

    // called on a falling edge, returns on the next one
    task automatic send_pixel(input pix_t p);
        int t;
        t = 0;
        while (full_o && t < TIMEOUT) begin   // source holds off
            @(negedge ui_clk);
            t++;
        end
        if (full_o)
            abort_run("FIFO stayed full");
        pix_valid_i = 1'b1;
        pix_i       = p;
        @(negedge ui_clk);
        pix_valid_i = 1'b0;
    endtask

    // DMA engine model
    initial begin : engine
        int t;
        int dly;
        for (int b = 0; b < FRAMES * BURSTS; b++) begin
            t = 0;
            while (wareq_o !== 1'b1 && t < TIMEOUT) begin
                @(negedge ui_clk);
                t++;
            end
            if (wareq_o !== 1'b1)
                abort_run("no write request from the DUT");
            got_addr.push_back(waddr_o);
            assert (wsize_o == SIZE_W'(BEATS)) else begin
                $display("ERR wsize_o: got %h expected %h", wsize_o, SIZE_W'(BEATS));
                errors++;
            end
            dly = take_bits(eng_st, 3);
            repeat (dly) @(negedge ui_clk);
            dma_busy_i = 1'b1;
            t = 0;
            while (wareq_o !== 1'b0 && t < TIMEOUT) begin
                @(negedge ui_clk);
                t++;
            end
            if (wareq_o !== 1'b0)
                abort_run("request still high after busy");
            for (int n = 0; n < BEATS; n++) begin
                if (take_bits(eng_st, 1) != 0)
                    @(negedge ui_clk);
                dma_wvalid_i = 1'b1;
                got_beat.push_back(wdata_o);   // fwft head
                @(negedge ui_clk);
                dma_wvalid_i = 1'b0;
            end
            dma_busy_i = 1'b0;
            bursts_seen++;
            @(negedge ui_clk);
        end
    end

    always @(negedge ui_clk) begin : compare
        addr_t ea;
        beat_t eb;
        if (wareq_o === 1'b1) begin
            assert (vdma_write_top_i.fifo_level >= SIZE_W'(BEATS)) else begin
                $display("ERR fifo_level at request: got %h expected at least %h",
                         vdma_write_top_i.fifo_level, SIZE_W'(BEATS));
                errors++;
            end
        end
        while (got_addr.size() > 0 && exp_addr.size() > 0) begin
            ea = exp_addr.pop_front();
            assert (got_addr[0] == ea) else begin
                $display("ERR waddr_o: got %h expected %h", got_addr[0], ea);
                errors++;
            end
            void'(got_addr.pop_front());
        end
        while (got_beat.size() > 0 && exp_beat.size() > 0) begin
            eb = exp_beat.pop_front();
            assert (got_beat[0] == eb) else begin
                $display("ERR wdata_o: got %h expected %h", got_beat[0], eb);
                errors++;
            end
            void'(got_beat.pop_front());
        end
    end

    initial begin : main
        int base_err;
        int t;
        int gap;
        pix_t p;
        pix_t first;
        ui_rstn      = 1'b0;
        fs_i         = 1'b0;
        pix_valid_i  = 1'b0;
        pix_i        = '0;
        buf_sel_i    = '0;
        base_addr_i  = BASE;
        dma_busy_i   = 1'b0;
        dma_wvalid_i = 1'b0;
        pix_st       = SEED;
        eng_st       = SEED;
        repeat (10) @(negedge ui_clk);
        ui_rstn = 1'b1;
        @(negedge ui_clk);

        base_err = errors;
        assert (wareq_o == 1'b0 && full_o == 1'b0 && sync_cnt_o == '0) else begin
            $display("ERR reset: wareq_o %h full_o %h sync_cnt_o %h expected 0 0 00",
                     wareq_o, full_o, sync_cnt_o);
            errors++;
        end
        assert (wready_o === 1'b1) else begin
            $display("ERR wready_o: got %h expected 1", wready_o);
            errors++;
        end
        report_test("reset values", base_err);

        for (int f = 0; f < FRAMES; f++) begin
            base_err = errors;
            for (int k = 0; k < BURSTS; k++)
                exp_addr.push_back(ref_addr(BASE, BUF_SEL[f], k));
            fs_i      = 1'b1;
            buf_sel_i = BUF_SEL[f];
            for (int i = 0; i < 18; i++) begin   // junk pixels that the flush drops
                pix_valid_i = 1'b1;
                pix_i       = take_bits(pix_st, 32);
                @(negedge ui_clk);
                if (i == 3)
                    fs_i = 1'b0;
            end
            pix_valid_i = 1'b0;
            buf_sel_i   = ~BUF_SEL[f];   // latched at frame start
            assert (sync_cnt_o == bufn_t'((f + 1) % BUF_COUNT)) else begin
                $display("ERR sync_cnt_o: got %h expected %h",
                         sync_cnt_o, bufn_t'((f + 1) % BUF_COUNT));
                errors++;
            end
            for (int n = 0; n < X_SIZE * Y_SIZE; n++) begin
                gap = take_bits(pix_st, 2);
                repeat (gap) @(negedge ui_clk);
                p = take_bits(pix_st, 32);
                send_pixel(p);
                if (n % 2 == 0)
                    first = p;
                else
                    exp_beat.push_back(ref_beat(first, p));
            end
            t = 0;
            while (bursts_seen < (f + 1) * BURSTS && t < TIMEOUT) begin
                @(negedge ui_clk);
                t++;
            end
            if (bursts_seen < (f + 1) * BURSTS)
                abort_run("frame bursts did not complete");
            @(negedge ui_clk);
            assert (exp_beat.size() == 0 && got_beat.size() == 0) else begin
                $display("beat count mismatch: %0d expected beats unmatched, %0d popped unmatched",
                         exp_beat.size(), got_beat.size());
                errors++;
            end
            report_test($sformatf("frame %0d", f), base_err);

            // extra pixels after the frame must not start a burst
            base_err = errors;
            for (int n = 0; n < 8; n++)
                send_pixel(take_bits(pix_st, 32));
            for (int c = 0; c < 20; c++) begin
                assert (wareq_o == 1'b0) else begin
                    $display("ERR wareq_o after last burst: got %h expected 0", wareq_o);
                    errors++;
                end
                @(negedge ui_clk);
            end
            report_test($sformatf("idle after frame %0d", f), base_err);
        end

        $display("tests %0d, failed %0d, errors %0d", tests, failed, errors);
        if (errors == 0)
            $display("** PASS **");
        else
            $display("** FAIL **");
        $finish;
    end

endmodule
